// File: list.f
+incdir+.
axi_lite_pkg.sv
axi_lite_ctrl.sv
axi_lite_regs.sv
axi_lite_rd_path.sv
axi_lite_v1_0_wrap.sv
tb.sv

// File: tb_table.svh
`ifndef TB_TABLE_SVH
`define TB_TABLE_SVH

// Columns: op, byte address, write data, strobe, expected response, expected read data.
// Word 3 counts OKAY writes, so its expected value follows the writes above it.
localparam int NUM_ENTRIES = 26;

task automatic load_stimulus();
	add_entry(OP_RD, 4'h0, 32'h0000_0000, 4'b0000, OKAY,   32'h0000_0000);
	add_entry(OP_RD, 4'h4, 32'h0000_0000, 4'b0000, OKAY,   32'h0000_0000);
	add_entry(OP_RD, 4'h8, 32'h0000_0000, 4'b0000, OKAY,   32'h0000_0000);
	add_entry(OP_RD, 4'hc, 32'h0000_0000, 4'b0000, OKAY,   32'h0000_0000);
	add_entry(OP_WR, 4'h0, 32'h1234_5678, 4'b1111, OKAY,   32'h0000_0000);
	add_entry(OP_WR, 4'h0, 32'h0000_0000, 4'b1000, OKAY,   32'h0000_0000);
	add_entry(OP_RD, 4'h0, 32'h0000_0000, 4'b0000, OKAY,   32'h0034_5678);
	add_entry(OP_WR, 4'h4, 32'hcafe_f00d, 4'b1111, OKAY,   32'h0000_0000);
	add_entry(OP_WR, 4'h8, 32'ha5a5_a5a5, 4'b1111, OKAY,   32'h0000_0000);
	add_entry(OP_RD, 4'h4, 32'h0000_0000, 4'b0000, OKAY,   32'hcafe_f00d);
	add_entry(OP_RD, 4'h8, 32'h0000_0000, 4'b0000, OKAY,   32'ha5a5_a5a5);
	add_entry(OP_RD, 4'hc, 32'h0000_0000, 4'b0000, OKAY,   32'h0000_0004);
	add_entry(OP_WR, 4'hc, 32'hffff_ffff, 4'b1111, SLVERR, 32'h0000_0000);
	add_entry(OP_RD, 4'hc, 32'h0000_0000, 4'b0000, OKAY,   32'h0000_0004);
	add_entry(OP_WR, 4'h6, 32'h0000_1234, 4'b0011, OKAY,   32'h0000_0000);
	add_entry(OP_WR, 4'h9, 32'h00bb_0000, 4'b0100, OKAY,   32'h0000_0000);
	add_entry(OP_WR, 4'h0, 32'hffff_ff11, 4'b0001, OKAY,   32'h0000_0000);
	add_entry(OP_RD, 4'h8, 32'h0000_0000, 4'b0000, OKAY,   32'ha5bb_a5a5);
	add_entry(OP_RD, 4'hc, 32'h0000_0000, 4'b0000, OKAY,   32'h0000_0007);
	add_entry(OP_RD, 4'h1, 32'h0000_0000, 4'b0000, OKAY,   32'h0034_5611);
	add_entry(OP_RD, 4'h4, 32'h0000_0000, 4'b0000, OKAY,   32'hcafe_1234);
	add_entry(OP_WR, 4'hf, 32'h0000_0001, 4'b0001, SLVERR, 32'h0000_0000);
	add_entry(OP_RD, 4'hf, 32'h0000_0000, 4'b0000, OKAY,   32'h0000_0007);
	add_entry(OP_WR, 4'h4, 32'hffff_ffff, 4'b0000, OKAY,   32'h0000_0000);
	add_entry(OP_RD, 4'h4, 32'h0000_0000, 4'b0000, OKAY,   32'hcafe_1234);
	add_entry(OP_RD, 4'hc, 32'h0000_0000, 4'b0000, OKAY,   32'h0000_0008);
endtask

`endif

// File: tb.sv
`timescale 1ns/1ps
`default_nettype none

module tb;

	localparam bit OP_WR = 1'b1;
	localparam bit OP_RD = 1'b0;
	localparam axi_lite_pkg::resp_t OKAY   = axi_lite_pkg::RESP_OKAY;
	localparam axi_lite_pkg::resp_t SLVERR = axi_lite_pkg::RESP_SLVERR;

	typedef struct packed {
		logic                op;
		axi_lite_pkg::addr_t addr;
		axi_lite_pkg::data_t data;
		axi_lite_pkg::strb_t strb;
		axi_lite_pkg::resp_t resp;
		axi_lite_pkg::data_t rdata;
	} entry_t;

	logic                s00_axi_aclk;
	logic                arst_n;
	axi_lite_pkg::addr_t awaddr;
	logic                awvalid;
	logic                awready;
	axi_lite_pkg::data_t wdata;
	axi_lite_pkg::strb_t wstrb;
	logic                wvalid;
	logic                wready;
	axi_lite_pkg::resp_t bresp;
	logic                bvalid;
	logic                bready;
	axi_lite_pkg::addr_t araddr;
	logic                arvalid;
	logic                arready;
	axi_lite_pkg::data_t rdata;
	axi_lite_pkg::resp_t rresp;
	logic                rvalid;
	logic                rready;

	int                  error_count = 0;
	int                  check_count = 0;
	int                  stim_count  = 0;
	int                  cycle_count = 0;
	axi_lite_pkg::data_t model_regs [4];

	axi_lite_v1_0_wrap u_axi_lite_v1_0_wrap (
		.s00_axi_aclk    (s00_axi_aclk),
		.arst_n          (arst_n),
		.s00_axi_awaddr  (awaddr),
		.s00_axi_awvalid (awvalid),
		.s00_axi_awready (awready),
		.s00_axi_wdata   (wdata),
		.s00_axi_wstrb   (wstrb),
		.s00_axi_wvalid  (wvalid),
		.s00_axi_wready  (wready),
		.s00_axi_bresp   (bresp),
		.s00_axi_bvalid  (bvalid),
		.s00_axi_bready  (bready),
		.s00_axi_araddr  (araddr),
		.s00_axi_arvalid (arvalid),
		.s00_axi_arready (arready),
		.s00_axi_rdata   (rdata),
		.s00_axi_rresp   (rresp),
		.s00_axi_rvalid  (rvalid),
		.s00_axi_rready  (rready)
	);

	`include "tb_table.svh"

	entry_t stim [NUM_ENTRIES];

	task automatic add_entry(
		input logic                op,
		input axi_lite_pkg::addr_t addr,
		input axi_lite_pkg::data_t data,
		input axi_lite_pkg::strb_t strb,
		input axi_lite_pkg::resp_t resp,
		input axi_lite_pkg::data_t exp_rdata
	);
		if (stim_count < NUM_ENTRIES) begin
			stim[stim_count] = '{op, addr, data, strb, resp, exp_rdata};
		end
		stim_count++;
	endtask

	localparam int CYCLE_LIMIT = NUM_ENTRIES * 12 + 50;

	task automatic check_value(
		input string       name,
		input logic [31:0] got,
		input logic [31:0] exp
	);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	// Reference register file. Strobed bytes replace old bytes and word 3 counts OKAY writes.
	task automatic model_write(
		input  axi_lite_pkg::addr_t addr,
		input  axi_lite_pkg::data_t data,
		input  axi_lite_pkg::strb_t strb,
		output axi_lite_pkg::resp_t resp
	);
		logic [1:0]          idx;
		axi_lite_pkg::data_t mask;
		idx  = addr[3:2];
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		if (idx == 2'd3) begin
			resp = SLVERR;
		end else begin
			model_regs[idx] = (model_regs[idx] & ~mask) | (data & mask);
			model_regs[3]   = model_regs[3] + 32'd1;
			resp            = OKAY;
		end
	endtask

	task automatic write_txn(
		input  axi_lite_pkg::addr_t addr,
		input  axi_lite_pkg::data_t data,
		input  axi_lite_pkg::strb_t strb,
		input  int                  delay,
		output axi_lite_pkg::resp_t resp
	);
		@(negedge s00_axi_aclk);
		awaddr  = addr;
		wdata   = data;
		wstrb   = strb;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		@(posedge s00_axi_aclk);
		while (!awready) begin
			@(posedge s00_axi_aclk);
		end
		check_value("wready", wready, 1'b1);
		@(negedge s00_axi_aclk);
		check_value("bvalid", bvalid, 1'b1); // One cycle after acceptance.
		repeat (delay) begin
			check_value("bvalid", bvalid, 1'b1);
			check_value("awready", awready, 1'b0); // Address and data are still offered.
			check_value("wready", wready, 1'b0);
			@(negedge s00_axi_aclk);
		end
		awvalid = 1'b0;
		wvalid  = 1'b0;
		bready  = 1'b1;
		@(posedge s00_axi_aclk);
		check_value("bvalid", bvalid, 1'b1);
		resp = bresp;
		@(negedge s00_axi_aclk);
		bready = 1'b0;
		check_value("bvalid", bvalid, 1'b0);
	endtask

	task automatic read_txn(
		input  axi_lite_pkg::addr_t addr,
		input  int                  delay,
		output axi_lite_pkg::data_t data,
		output axi_lite_pkg::resp_t resp
	);
		axi_lite_pkg::data_t held;
		@(negedge s00_axi_aclk);
		araddr  = addr;
		arvalid = 1'b1;
		@(posedge s00_axi_aclk);
		while (!arready) begin
			@(posedge s00_axi_aclk);
		end
		@(negedge s00_axi_aclk);
		check_value("rvalid", rvalid, 1'b1);
		held = rdata;
		repeat (delay) begin
			check_value("rvalid", rvalid, 1'b1);
			check_value("rdata", rdata, held); // Must not move while rready is low.
			check_value("arready", arready, 1'b0); // The address is still offered.
			@(negedge s00_axi_aclk);
		end
		arvalid = 1'b0;
		rready  = 1'b1;
		@(posedge s00_axi_aclk);
		check_value("rvalid", rvalid, 1'b1);
		data = rdata;
		resp = rresp;
		@(negedge s00_axi_aclk);
		rready = 1'b0;
		check_value("rvalid", rvalid, 1'b0);
	endtask

	initial begin
		s00_axi_aclk = 1'b0;
		forever #50 s00_axi_aclk = ~s00_axi_aclk;
	end

	initial begin
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge s00_axi_aclk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles.", CYCLE_LIMIT);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		int unsigned         rand_init;
		int                  delay;
		axi_lite_pkg::resp_t got_resp;
		axi_lite_pkg::resp_t model_resp;
		axi_lite_pkg::data_t got_data;

		rand_init = $urandom(91);
		arst_n    = 1'b0;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = '0;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		for (int w = 0; w < 4; w++) begin
			model_regs[w] = '0;
		end
		load_stimulus();
		if (stim_count != NUM_ENTRIES) begin
			error_count++;
			$display("The stimulus table holds %0d entries instead of %0d.",
				stim_count, NUM_ENTRIES);
		end

		repeat (5) begin
			@(negedge s00_axi_aclk);
			check_value("awready", awready, 1'b0);
			check_value("wready", wready, 1'b0);
			check_value("bvalid", bvalid, 1'b0);
			check_value("arready", arready, 1'b0);
			check_value("rvalid", rvalid, 1'b0);
		end
		arst_n = 1'b1;

		for (int i = 0; i < NUM_ENTRIES; i++) begin
			delay = $urandom % 4;
			if (stim[i].op == OP_WR) begin
				model_write(stim[i].addr, stim[i].data, stim[i].strb, model_resp);
				check_value("model bresp", model_resp, stim[i].resp);
				write_txn(stim[i].addr, stim[i].data, stim[i].strb, delay, got_resp);
				check_value("bresp", got_resp, stim[i].resp);
			end else begin
				check_value("model rdata", model_regs[stim[i].addr[3:2]], stim[i].rdata);
				read_txn(stim[i].addr, delay, got_data, got_resp);
				check_value("rdata", got_data, stim[i].rdata);
				check_value("rresp", got_resp, OKAY);
			end
		end

		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: axi_lite_v1_0_wrap.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_v1_0_wrap (
	input  logic                s00_axi_aclk,
	input  logic                arst_n,

	input  axi_lite_pkg::addr_t s00_axi_awaddr,
	input  logic                s00_axi_awvalid,
	output logic                s00_axi_awready,

	input  axi_lite_pkg::data_t s00_axi_wdata,
	input  axi_lite_pkg::strb_t s00_axi_wstrb,
	input  logic                s00_axi_wvalid,
	output logic                s00_axi_wready,

	output axi_lite_pkg::resp_t s00_axi_bresp,
	output logic                s00_axi_bvalid,
	input  logic                s00_axi_bready,

	input  axi_lite_pkg::addr_t s00_axi_araddr,
	input  logic                s00_axi_arvalid,
	output logic                s00_axi_arready,

	output axi_lite_pkg::data_t s00_axi_rdata,
	output axi_lite_pkg::resp_t s00_axi_rresp,
	output logic                s00_axi_rvalid,
	input  logic                s00_axi_rready
);

	logic                        wr_en;
	axi_lite_pkg::wr_req_t       wr_req;
	logic                        rd_en;
	axi_lite_pkg::reg_idx_t      rd_idx;
	axi_lite_pkg::data_t [3:0]   regs;

	axi_lite_ctrl u_ctrl (
		.s00_axi_aclk (s00_axi_aclk),
		.arst_n       (arst_n),
		.awvalid      (s00_axi_awvalid),
		.wvalid       (s00_axi_wvalid),
		.bready       (s00_axi_bready),
		.arvalid      (s00_axi_arvalid),
		.rready       (s00_axi_rready),
		.awaddr       (s00_axi_awaddr),
		.wdata        (s00_axi_wdata),
		.wstrb        (s00_axi_wstrb),
		.araddr       (s00_axi_araddr),
		.awready      (s00_axi_awready),
		.wready       (s00_axi_wready),
		.bvalid       (s00_axi_bvalid),
		.arready      (s00_axi_arready),
		.rvalid       (s00_axi_rvalid),
		.wr_en        (wr_en),
		.wr_req       (wr_req),
		.rd_en        (rd_en),
		.rd_idx       (rd_idx)
	);

	// The write response comes straight from the register block.
	axi_lite_regs u_regs (
		.s00_axi_aclk (s00_axi_aclk),
		.arst_n       (arst_n),
		.wr_en        (wr_en),
		.wr_req       (wr_req),
		.wr_resp      (s00_axi_bresp),
		.regs         (regs)
	);

	axi_lite_rd_path u_rd_path (
		.s00_axi_aclk (s00_axi_aclk),
		.arst_n       (arst_n),
		.rd_en        (rd_en),
		.rd_idx       (rd_idx),
		.regs         (regs),
		.rdata        (s00_axi_rdata)
	);

	assign s00_axi_rresp = axi_lite_pkg::RESP_OKAY; // Every word is readable.

endmodule

`default_nettype wire

// File: axi_lite_rd_path.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_rd_path (
	input  logic                        s00_axi_aclk,
	input  logic                        arst_n,

	input  logic                        rd_en,
	input  axi_lite_pkg::reg_idx_t      rd_idx,
	input  axi_lite_pkg::data_t [3:0]   regs,

	output axi_lite_pkg::data_t         rdata
);

	axi_lite_pkg::data_t rd_word;

	// Word selected by the read address on the acceptance cycle.
	assign rd_word = regs[rd_idx];

	// Capturing on the same edge as a write returns the old word, because
	// regs still holds the value from before that edge.
	always_ff @(posedge s00_axi_aclk or negedge arst_n) begin
		if (!arst_n) begin
			rdata <= '0;
		end else if (rd_en) begin
			rdata <= rd_word;
		end
	end

endmodule

`default_nettype wire

// File: axi_lite_regs.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_regs (
	input  logic                        s00_axi_aclk,
	input  logic                        arst_n,

	input  logic                        wr_en,
	input  axi_lite_pkg::wr_req_t       wr_req,

	output axi_lite_pkg::resp_t         wr_resp,
	output axi_lite_pkg::data_t [3:0]   regs
);

	localparam int unsigned BYTE_W = axi_lite_pkg::DATA_W / axi_lite_pkg::STRB_W;

	logic                wr_ro;
	axi_lite_pkg::data_t merged;
	axi_lite_pkg::data_t count_nxt;

	// Replaces each strobed byte lane of the old word with the new data.
	function automatic axi_lite_pkg::data_t merge_bytes(
		input axi_lite_pkg::data_t old_word,
		input axi_lite_pkg::data_t new_word,
		input axi_lite_pkg::strb_t strb
	);
		axi_lite_pkg::data_t result;
		result = old_word;
		for (int b = 0; b < axi_lite_pkg::STRB_W; b++) begin
			if (strb[b]) begin
				result[b*BYTE_W +: BYTE_W] = new_word[b*BYTE_W +: BYTE_W];
			end
		end
		return result;
	endfunction

	assign wr_ro     = (wr_req.idx == axi_lite_pkg::RO_IDX);
	assign merged    = merge_bytes(regs[wr_req.idx], wr_req.data, wr_req.strb);
	assign count_nxt = regs[axi_lite_pkg::RO_IDX] + axi_lite_pkg::data_t'(1);

	always_ff @(posedge s00_axi_aclk or negedge arst_n) begin
		if (!arst_n) begin
			regs <= '0;
		end else if (wr_en && !wr_ro) begin
			regs[wr_req.idx]            <= merged;
			regs[axi_lite_pkg::RO_IDX]  <= count_nxt; // Counts OKAY writes only.
		end
	end

	// The response is held until the next accepted write, so it stays
	// valid for as long as the master keeps bready low.
	always_ff @(posedge s00_axi_aclk or negedge arst_n) begin
		if (!arst_n) begin
			wr_resp <= axi_lite_pkg::RESP_OKAY;
		end else if (wr_en) begin
			if (wr_ro) begin
				wr_resp <= axi_lite_pkg::RESP_SLVERR;
			end else begin
				wr_resp <= axi_lite_pkg::RESP_OKAY;
			end
		end
	end

endmodule

`default_nettype wire

// File: axi_lite_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_ctrl (
	input  logic                   s00_axi_aclk,
	input  logic                   arst_n,

	input  logic                   awvalid,
	input  logic                   wvalid,
	input  logic                   bready,
	input  logic                   arvalid,
	input  logic                   rready,

	input  axi_lite_pkg::addr_t    awaddr,
	input  axi_lite_pkg::data_t    wdata,
	input  axi_lite_pkg::strb_t    wstrb,
	input  axi_lite_pkg::addr_t    araddr,

	output logic                   awready,
	output logic                   wready,
	output logic                   bvalid,
	output logic                   arready,
	output logic                   rvalid,

	output logic                   wr_en,
	output axi_lite_pkg::wr_req_t  wr_req,
	output logic                   rd_en,
	output axi_lite_pkg::reg_idx_t rd_idx
);

	axi_lite_pkg::wr_state_t wr_state;
	axi_lite_pkg::wr_state_t wr_state_nxt;
	axi_lite_pkg::rd_state_t rd_state;
	axi_lite_pkg::rd_state_t rd_state_nxt;

	logic wr_accept;
	logic rd_accept;

	// Address and data must arrive together, a lone channel is left waiting.
	assign wr_accept = (wr_state == axi_lite_pkg::WR_IDLE) && awvalid && wvalid;
	assign rd_accept = (rd_state == axi_lite_pkg::RD_IDLE) && arvalid;

	always_comb begin
		wr_state_nxt = wr_state;
		case (wr_state)
			axi_lite_pkg::WR_IDLE: begin
				if (wr_accept) begin
					wr_state_nxt = axi_lite_pkg::WR_RESP;
				end
			end
			axi_lite_pkg::WR_RESP: begin
				if (bready) begin
					wr_state_nxt = axi_lite_pkg::WR_IDLE; // Response taken by the master.
				end
			end
			default: begin
				wr_state_nxt = axi_lite_pkg::WR_IDLE;
			end
		endcase
	end

	always_comb begin
		rd_state_nxt = rd_state;
		case (rd_state)
			axi_lite_pkg::RD_IDLE: begin
				if (rd_accept) begin
					rd_state_nxt = axi_lite_pkg::RD_DATA;
				end
			end
			axi_lite_pkg::RD_DATA: begin
				if (rready) begin
					rd_state_nxt = axi_lite_pkg::RD_IDLE;
				end
			end
			default: begin
				rd_state_nxt = axi_lite_pkg::RD_IDLE;
			end
		endcase
	end

	always_ff @(posedge s00_axi_aclk or negedge arst_n) begin
		if (!arst_n) begin
			wr_state <= axi_lite_pkg::WR_IDLE;
			rd_state <= axi_lite_pkg::RD_IDLE;
		end else begin
			wr_state <= wr_state_nxt;
			rd_state <= rd_state_nxt;
		end
	end

	// Ready is a single-cycle pulse, since the state leaves idle on the same edge.
	assign awready = wr_accept;
	assign wready  = wr_accept;
	assign arready = rd_accept;

	assign bvalid = (wr_state == axi_lite_pkg::WR_RESP);
	assign rvalid = (rd_state == axi_lite_pkg::RD_DATA);

	// The register block updates on the acceptance edge.
	assign wr_en  = wr_accept;
	assign wr_req = '{idx: awaddr[3:2], data: wdata, strb: wstrb};

	assign rd_en  = rd_accept;
	assign rd_idx = araddr[3:2]; // Bits 1 to 0 are ignored.

endmodule

`default_nettype wire

// File: axi_lite_pkg.sv
`default_nettype none

package axi_lite_pkg;

	localparam int unsigned DATA_W = 32;
	localparam int unsigned ADDR_W = 4;
	localparam int unsigned STRB_W = 4; // One strobe per byte lane.

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [STRB_W-1:0] strb_t;

	// Word index taken from address bits 3 to 2.
	typedef logic [1:0] reg_idx_t;

	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// The last word holds the count of accepted writes and cannot be written.
	localparam reg_idx_t RO_IDX = 2'd3;

	typedef struct packed {
		reg_idx_t idx;
		data_t    data;
		strb_t    strb;
	} wr_req_t;

	typedef enum logic {
		WR_IDLE,
		WR_RESP
	} wr_state_t;

	typedef enum logic {
		RD_IDLE,
		RD_DATA
	} rd_state_t;

endpackage

`default_nettype wire
